/* vlog.f */
img_pkg.sv
img_ctrl.sv
frame_capture.sv
pixel_stats.sv
frame_store.sv
img_controller.sv
img_controller_tb.sv

/* Makefile */
# Verilator build and run for the image capture controller

VERILATOR ?= verilator
TOP       ?= img_controller_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* img_controller_tb.sv */
`timescale 1ns/10ps

module img_controller_tb;

    // Pixel patterns used by the stimulus table
    localparam int PAT_RAMP = 0;
    localparam int PAT_HIGH = 1;
    localparam int PAT_LOW = 2;
    localparam int PAT_RAND = 3;
    localparam int NUM_ROWS = 5;
    localparam int WAIT_LIMIT = 2000;

    logic                                  clk;
    logic                                  fifoIn_rst;
    logic                                  cmd_capture;
    logic                                  cmd_readout;
    logic                                  cmd_ram_block;
    logic [img_pkg::PIXEL_WIDTH-1:0]       img_d;
    logic                                  img_fv;
    logic                                  img_lv;
    logic                                  readout_trigger;
    logic                                  readout_ready;
    logic [img_pkg::WORD_WIDTH-1:0]        readout_data;
    logic                                  status_capture_done;
    logic [img_pkg::COUNT_WIDTH-1:0]       status_pixel_count;
    logic [img_pkg::STAT_WIDTH-1:0]        status_highlight_count;
    logic [img_pkg::STAT_WIDTH-1:0]        status_shadow_count;

    // Capture block, lines, line length, pattern, readout block, back-pressure
    int stim [0:NUM_ROWS-1][0:5] = '{
        '{0, 4, 8, PAT_RAMP, 0, 0},
        '{1, 3, 8, PAT_HIGH, 0, 0},
        '{1, 5, 8, PAT_LOW, 1, 1},
        '{0, 9, 8, PAT_RAND, 0, 1},
        '{1, 3, 5, PAT_RAND, 1, 1}
    };

    // Reference model state
    logic [img_pkg::PIXEL_WIDTH-1:0]  pix [0:127];
    logic [img_pkg::WORD_WIDTH-1:0]   model_mem [0:1][0:img_pkg::BLOCK_WORDS-1];
    int                               exp_count;
    int                               exp_hl;
    int                               exp_sh;

    img_controller img_controller_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ====================================================================
    // Helpers
    // ====================================================================
    // Inputs change 1 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Fail at %0t: %s expected %0h got %0h",
                               $time, name, expected, actual));
        end
    endtask

    // Pixel values for one frame, in raster order
    task automatic fill_pixels(input int pattern, input int n);
        for (int k = 0; k < n; k++) begin
            case (pattern)
                PAT_RAMP: pix[k] = 12'(k * 67);
                PAT_HIGH: pix[k] = '1;
                PAT_LOW:  pix[k] = '0;
                default:  pix[k] = 12'($urandom);
            endcase
        end
    endtask

    // ====================================================================
    // Reference model
    // ====================================================================
    task automatic build_expected(input int blk, input int lines, input int len);
        img_pkg::img_word_t w;
        int n;
        n = lines * len;
        exp_hl = 0;
        exp_sh = 0;
        // Header is all ones
        for (int k = 0; k < img_pkg::HEADER_WORDS; k++) begin
            model_mem[blk][k] = '1;
        end
        for (int idx = 0; idx < n; idx++) begin
            // Anything past one block is dropped
            if (idx < img_pkg::IMG_SIZE_MAX) begin
                w.pix.pad = '0;
                w.pix.pixel = pix[idx];
                model_mem[blk][img_pkg::HEADER_WORDS + idx] = w.raw;
                // Grid sample every 4th column of every 4th line
                if ((idx / len) % 4 == 0 && (idx % len) % 4 == 0) begin
                    if (pix[idx][11:5] == 7'h7f) exp_hl++;
                    if (pix[idx][11:5] == 7'h00) exp_sh++;
                end
            end
        end
        if (n > img_pkg::IMG_SIZE_MAX) begin
            exp_count = img_pkg::BLOCK_WORDS;
        end else begin
            exp_count = img_pkg::HEADER_WORDS + n;
        end
    endtask

    // ====================================================================
    // Sensor driver and readout
    // ====================================================================
    task automatic drive_frame(input int lines, input int len);
        // Blanking ahead of the frame
        repeat (6) next_cycle();
        img_fv = 1'b1;
        repeat (12) next_cycle();
        for (int i = 0; i < lines; i++) begin
            for (int j = 0; j < len; j++) begin
                img_lv = 1'b1;
                img_d = pix[i * len + j];
                next_cycle();
            end
            img_lv = 1'b0;
            repeat (3) next_cycle();
        end
        img_fv = 1'b0;
    endtask

    task automatic wait_capture_done();
        img_pkg::ctrl_state_t st;
        int waited;
        waited = 0;
        while (!status_capture_done) begin
            if (waited == WAIT_LIMIT) begin
                st = img_controller_i.img_ctrl_i.state;
                fail_run($sformatf("Timeout waiting for capture done, control in %s",
                                   st.name()));
            end
            next_cycle();
            waited++;
        end
    endtask

    task automatic read_block(input int blk, input int gaps);
        logic [img_pkg::WORD_WIDTH-1:0] held_data;
        logic held;
        int got;
        int waited;
        got = 0;
        waited = 0;
        held = 1'b0;
        held_data = '0;
        cmd_readout = 1'b1;
        cmd_ram_block = (blk != 0);
        next_cycle();
        cmd_readout = 1'b0;
        while (got < exp_count) begin
            if (waited == WAIT_LIMIT) begin
                fail_run($sformatf("Timeout waiting for readout word %0d of %0d",
                                   got, exp_count));
            end
            // Word must not move while trigger was low
            if (held && readout_ready) begin
                check_value("readout_data held", held_data, readout_data);
            end
            readout_trigger = (gaps == 0) || ($urandom % 3 != 0);
            if (readout_ready && readout_trigger) begin
                check_value($sformatf("readout_data[%0d]", got),
                            model_mem[blk][got], readout_data);
                got++;
            end
            held = readout_ready && !readout_trigger;
            held_data = readout_data;
            next_cycle();
            waited++;
        end
        readout_trigger = 1'b0;
        // Ready drops right after the last word, no extra word
        check_value("readout_ready", 0, readout_ready);
        next_cycle();
        check_value("readout_ready", 0, readout_ready);
    endtask

    // ====================================================================
    // Main sequence
    // ====================================================================
    initial begin
        int r;
        void'($urandom(32'ha76c_f30d));
        fifoIn_rst = 1'b0;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_ram_block = 1'b0;
        img_d = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        readout_trigger = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        fifoIn_rst = 1'b1;
        next_cycle();

        // Idle outputs out of reset
        check_value("readout_ready", 0, readout_ready);
        check_value("status_capture_done", 0, status_capture_done);
        check_value("status_pixel_count", 0, status_pixel_count);
        check_value("status_highlight_count", 0, status_highlight_count);
        check_value("status_shadow_count", 0, status_shadow_count);

        for (r = 0; r < NUM_ROWS; r++) begin
            fill_pixels(stim[r][3], stim[r][1] * stim[r][2]);
            build_expected(stim[r][0], stim[r][1], stim[r][2]);
            cmd_capture = 1'b1;
            cmd_ram_block = (stim[r][0] != 0);
            next_cycle();
            cmd_capture = 1'b0;
            drive_frame(stim[r][1], stim[r][2]);
            wait_capture_done();
            check_value("status_pixel_count", exp_count, status_pixel_count);
            check_value("status_highlight_count", exp_hl, status_highlight_count);
            check_value("status_shadow_count", exp_sh, status_shadow_count);
            repeat (2) next_cycle();
            read_block(stim[r][4], stim[r][5]);
            repeat (2) next_cycle();
        end

        $display("sim passed");
        $finish;
    end

endmodule

/* img_controller.sv */
`timescale 1ns/10ps

module img_controller (
    input  logic                               clk,
    input  logic                               fifoIn_rst,
    // Commands
    input  logic                               cmd_capture,
    input  logic                               cmd_readout,
    input  logic                               cmd_ram_block,
    // Image sensor
    input  logic [img_pkg::PIXEL_WIDTH-1:0]    img_d,
    input  logic                               img_fv,
    input  logic                               img_lv,
    // Readout port
    input  logic                               readout_trigger,
    output logic                               readout_ready,
    output logic [img_pkg::WORD_WIDTH-1:0]     readout_data,
    // Status
    output logic                               status_capture_done,
    output logic [img_pkg::COUNT_WIDTH-1:0]    status_pixel_count,
    output logic [img_pkg::STAT_WIDTH-1:0]     status_highlight_count,
    output logic [img_pkg::STAT_WIDTH-1:0]     status_shadow_count
);

    // Control to datapath
    logic                               cap_start;
    logic                               rd_start;
    logic                               block_sel;
    logic                               cap_done;
    logic                               rd_done;
    // Capture to store
    logic                               wr_en;
    logic [img_pkg::COUNT_WIDTH-1:0]    wr_addr;
    img_pkg::img_word_t                 wr_data;
    // Capture to statistics
    logic                               pix_fv;
    logic                               pix_lv;
    logic [img_pkg::PIXEL_WIDTH-1:0]    pix_data;
    logic                               pix_write;

    img_ctrl img_ctrl_i (
        .clk                    (clk),
        .fifoIn_rst             (fifoIn_rst),
        .cmd_capture            (cmd_capture),
        .cmd_readout            (cmd_readout),
        .cmd_ram_block          (cmd_ram_block),
        .cap_done               (cap_done),
        .rd_done                (rd_done),
        .cap_start              (cap_start),
        .rd_start               (rd_start),
        .block_sel              (block_sel),
        .status_capture_done    (status_capture_done)
    );

    frame_capture frame_capture_i (
        .clk                    (clk),
        .fifoIn_rst             (fifoIn_rst),
        .cap_start              (cap_start),
        .img_d                  (img_d),
        .img_fv                 (img_fv),
        .img_lv                 (img_lv),
        .cap_done               (cap_done),
        .wr_en                  (wr_en),
        .wr_addr                (wr_addr),
        .wr_data                (wr_data),
        .pix_fv                 (pix_fv),
        .pix_lv                 (pix_lv),
        .pix_data               (pix_data),
        .pix_write              (pix_write),
        .status_pixel_count     (status_pixel_count)
    );

    pixel_stats pixel_stats_i (
        .clk                    (clk),
        .fifoIn_rst             (fifoIn_rst),
        .cap_start              (cap_start),
        .pix_fv                 (pix_fv),
        .pix_lv                 (pix_lv),
        .pix_data               (pix_data),
        .pix_write              (pix_write),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count)
    );

    // Readout length is the last capture's word count
    frame_store frame_store_i (
        .clk                    (clk),
        .fifoIn_rst             (fifoIn_rst),
        .block_sel              (block_sel),
        .wr_en                  (wr_en),
        .wr_addr                (wr_addr),
        .wr_data                (wr_data),
        .rd_start               (rd_start),
        .rd_len                 (status_pixel_count),
        .readout_trigger        (readout_trigger),
        .readout_ready          (readout_ready),
        .readout_data           (readout_data),
        .rd_done                (rd_done)
    );

endmodule

/* frame_store.sv */
`timescale 1ns/10ps

module frame_store (
    input  logic                               clk,
    input  logic                               fifoIn_rst,
    input  logic                               block_sel,
    // Capture side
    input  logic                               wr_en,
    input  logic [img_pkg::COUNT_WIDTH-1:0]    wr_addr,
    input  img_pkg::img_word_t                 wr_data,
    // Readout side
    input  logic                               rd_start,
    input  logic [img_pkg::COUNT_WIDTH-1:0]    rd_len,
    input  logic                               readout_trigger,
    output logic                               readout_ready,
    output logic [img_pkg::WORD_WIDTH-1:0]     readout_data,
    output logic                               rd_done
);

    img_pkg::img_word_t                mem [0:2*img_pkg::BLOCK_WORDS-1];
    logic [img_pkg::COUNT_WIDTH-1:0]   rd_addr;
    logic [img_pkg::COUNT_WIDTH-1:0]   remaining;
    logic                              load_pending;
    logic                              xfer;
    logic                              last_word;
    logic                              load_word;

    // Block 1 sits right after block 0
    function automatic logic [img_pkg::COUNT_WIDTH:0] block_index(
        input logic                              blk,
        input logic [img_pkg::COUNT_WIDTH-1:0]   addr
    );
        logic [img_pkg::COUNT_WIDTH:0] base;
        base = blk ? (img_pkg::COUNT_WIDTH + 1)'(img_pkg::BLOCK_WORDS) : '0;
        return base + {1'b0, addr};
    endfunction

    // ====================================================================
    // Memory
    // ====================================================================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[block_index(block_sel, wr_addr)] <= wr_data;
        end
    end

    // Transfer happens on ready and trigger together
    assign xfer = readout_ready && readout_trigger;
    assign last_word = (remaining == img_pkg::COUNT_WIDTH'(1));

    // First fetch after start, then refill after each transfer
    assign load_word = !rd_start
                     && ((load_pending && remaining != '0) || (xfer && !last_word));

    // Output register, held while trigger is low
    always_ff @(posedge clk) begin
        if (load_word) begin
            readout_data <= mem[block_index(block_sel, rd_addr)].raw;
        end
    end

    // ====================================================================
    // Readout sequencing
    // ====================================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            readout_ready <= 1'b0;
            remaining <= '0;
            rd_addr <= '0;
            load_pending <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            if (rd_start) begin
                // Length frozen here
                remaining <= rd_len;
                rd_addr <= '0;
                load_pending <= 1'b1;
                readout_ready <= 1'b0;
            end else begin
                if (load_word) begin
                    rd_addr <= rd_addr + 1'b1;
                end
                if (load_pending) begin
                    load_pending <= 1'b0;
                    // Empty block finishes right away
                    if (remaining != '0) begin
                        readout_ready <= 1'b1;
                    end else begin
                        rd_done <= 1'b1;
                    end
                end
                if (xfer) begin
                    remaining <= remaining - 1'b1;
                    if (last_word) begin
                        readout_ready <= 1'b0;
                        rd_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* pixel_stats.sv */
`timescale 1ns/10ps

module pixel_stats (
    input  logic                               clk,
    input  logic                               fifoIn_rst,
    input  logic                               cap_start,
    input  logic                               pix_fv,
    input  logic                               pix_lv,
    input  logic [img_pkg::PIXEL_WIDTH-1:0]    pix_data,
    input  logic                               pix_write,
    output logic [img_pkg::STAT_WIDTH-1:0]     status_highlight_count,
    output logic [img_pkg::STAT_WIDTH-1:0]     status_shadow_count
);

    logic [1:0]                       col;
    logic [1:0]                       row;
    logic                             lv_prev;
    logic                             stat_valid;
    logic [img_pkg::STAT_BITS-1:0]    stat_top;

    // ====================================================================
    // Sparse grid position, one sample per 4x4 tile
    // ====================================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            col <= '0;
            row <= '0;
            lv_prev <= 1'b0;
            stat_valid <= 1'b0;
        end else begin
            lv_prev <= pix_lv;
            // Column restarts every line
            if (!pix_lv) begin
                col <= '0;
            end else begin
                col <= col + 1'b1;
            end
            // Row advances on lv falling edge
            if (!pix_fv) begin
                row <= '0;
            end else if (lv_prev && !pix_lv) begin
                row <= row + 1'b1;
            end
            stat_valid <= pix_write && (col == '0) && (row == '0);
        end
    end

    // Top bits of the sampled pixel
    always_ff @(posedge clk) begin
        stat_top <= pix_data[img_pkg::PIXEL_WIDTH-1 -: img_pkg::STAT_BITS];
    end

    // Counters, one cycle after the sample
    always_ff @(posedge clk) begin
        if (!fifoIn_rst || cap_start) begin
            status_highlight_count <= '0;
            status_shadow_count <= '0;
        end else if (stat_valid) begin
            if (stat_top == '1) begin
                status_highlight_count <= status_highlight_count + 1'b1;
            end
            if (stat_top == '0) begin
                status_shadow_count <= status_shadow_count + 1'b1;
            end
        end
    end

endmodule

/* frame_capture.sv */
`timescale 1ns/10ps

module frame_capture (
    input  logic                                clk,
    input  logic                                fifoIn_rst,
    input  logic                                cap_start,
    // Sensor pins
    input  logic [img_pkg::PIXEL_WIDTH-1:0]     img_d,
    input  logic                                img_fv,
    input  logic                                img_lv,
    output logic                                cap_done,
    // Store write port
    output logic                                wr_en,
    output logic [img_pkg::COUNT_WIDTH-1:0]     wr_addr,
    output img_pkg::img_word_t                  wr_data,
    // Registered sensor view for the statistics
    output logic                                pix_fv,
    output logic                                pix_lv,
    output logic [img_pkg::PIXEL_WIDTH-1:0]     pix_data,
    output logic                                pix_write,
    output logic [img_pkg::COUNT_WIDTH-1:0]     status_pixel_count
);

    logic [2:0]                           state;
    logic [img_pkg::HDR_CNT_WIDTH-1:0]    hdr_cnt;
    logic [img_pkg::COUNT_WIDTH-1:0]      word_count;
    logic                                 block_full;

    // ====================================================================
    // Input register stage
    // ====================================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            pix_fv <= 1'b0;
            pix_lv <= 1'b0;
        end else begin
            pix_fv <= img_fv;
            pix_lv <= img_lv;
        end
    end

    // Pixel value follows the pins
    always_ff @(posedge clk) begin
        pix_data <= img_d;
    end

    // ====================================================================
    // Frame-input state machine
    // ====================================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state <= img_pkg::CAP_IDLE;
            hdr_cnt <= '0;
        end else if (cap_start) begin
            state <= img_pkg::CAP_WAIT_LOW;
        end else begin
            case (state)
                // Skip any frame already in progress
                img_pkg::CAP_WAIT_LOW: begin
                    if (!pix_fv) begin
                        state <= img_pkg::CAP_WAIT_HIGH;
                    end
                end
                img_pkg::CAP_WAIT_HIGH: begin
                    if (pix_fv) begin
                        hdr_cnt <= img_pkg::HDR_CNT_WIDTH'(img_pkg::HEADER_WORDS - 1);
                        state <= img_pkg::CAP_HEADER;
                    end
                end
                // One header word per cycle
                img_pkg::CAP_HEADER: begin
                    hdr_cnt <= hdr_cnt - 1'b1;
                    if (hdr_cnt == '0) begin
                        state <= img_pkg::CAP_PIXELS;
                    end
                end
                img_pkg::CAP_PIXELS: begin
                    if (!pix_fv) begin
                        state <= img_pkg::CAP_IDLE;
                    end
                end
                default: begin
                    state <= img_pkg::CAP_IDLE;
                end
            endcase
        end
    end

    // End of frame seen while storing pixels
    assign cap_done = (state == img_pkg::CAP_PIXELS) && !pix_fv;

    // Words beyond one block are dropped
    assign block_full = (word_count == img_pkg::COUNT_WIDTH'(img_pkg::BLOCK_WORDS));

    // Only pixels inside fv and lv count, header-time lines are lost
    assign pix_write = (state == img_pkg::CAP_PIXELS) && pix_fv && pix_lv && !block_full;
    assign wr_en = ((state == img_pkg::CAP_HEADER) && !block_full) || pix_write;

    // Header is all ones, pixels get zero pad on top
    always_comb begin
        wr_data.raw = img_pkg::HEADER_WORD;
        if (state != img_pkg::CAP_HEADER) begin
            wr_data.pix.pad = '0;
            wr_data.pix.pixel = pix_data;
        end
    end

    // Word counter doubles as write address
    always_ff @(posedge clk) begin
        if (!fifoIn_rst || cap_start) begin
            word_count <= '0;
        end else if (wr_en) begin
            word_count <= word_count + 1'b1;
        end
    end

    assign wr_addr = word_count;
    assign status_pixel_count = word_count;

endmodule

/* img_ctrl.sv */
`timescale 1ns/10ps

module img_ctrl (
    input  logic clk,
    input  logic fifoIn_rst,
    // Command pulses from the host
    input  logic cmd_capture,
    input  logic cmd_readout,
    input  logic cmd_ram_block,
    // Done pulses from the datapath
    input  logic cap_done,
    input  logic rd_done,
    output logic cap_start,
    output logic rd_start,
    output logic block_sel,
    output logic status_capture_done
);

    img_pkg::ctrl_state_t state;

    // ====================================================================
    // Command sequencer
    // ====================================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state <= img_pkg::CTRL_IDLE;
            cap_start <= 1'b0;
            rd_start <= 1'b0;
            block_sel <= 1'b0;
            status_capture_done <= 1'b0;
        end else begin
            // Strobes default low
            cap_start <= 1'b0;
            rd_start <= 1'b0;
            status_capture_done <= 1'b0;

            case (state)
                img_pkg::CTRL_IDLE: begin
                    // Capture wins if both arrive together
                    if (cmd_capture) begin
                        block_sel <= cmd_ram_block;
                        cap_start <= 1'b1;
                        state <= img_pkg::CTRL_CAPTURE;
                    end else if (cmd_readout) begin
                        block_sel <= cmd_ram_block;
                        rd_start <= 1'b1;
                        state <= img_pkg::CTRL_READOUT;
                    end
                end

                img_pkg::CTRL_CAPTURE: begin
                    // Frame fully written once fv has dropped
                    if (cap_done) begin
                        status_capture_done <= 1'b1;
                        state <= img_pkg::CTRL_IDLE;
                    end
                end

                img_pkg::CTRL_READOUT: begin
                    if (rd_done) begin
                        state <= img_pkg::CTRL_IDLE;
                    end
                end

                default: begin
                    state <= img_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

endmodule

/* img_pkg.sv */
package img_pkg;

    // ====================================================================
    // Sizes
    // ====================================================================
    // Sensor pixel and stored word
    localparam int PIXEL_WIDTH = 12;
    localparam int WORD_WIDTH = 16;

    // Frame layout, header words ahead of the pixels
    localparam int HEADER_WORDS = 8;
    localparam int IMG_SIZE_MAX = 64;
    localparam int BLOCK_WORDS = HEADER_WORDS + IMG_SIZE_MAX;

    // Counts must be able to hold BLOCK_WORDS itself
    localparam int COUNT_WIDTH = $clog2(BLOCK_WORDS + 1);
    localparam int HDR_CNT_WIDTH = $clog2(HEADER_WORDS);

    // Highlight / shadow statistics
    localparam int STAT_WIDTH = 18;
    localparam int STAT_BITS = 7;

    localparam logic [WORD_WIDTH-1:0] HEADER_WORD = '1;

    // ====================================================================
    // State encodings
    // ====================================================================
    // Frame-input machine in frame_capture
    localparam logic [2:0] CAP_IDLE = 3'd0;
    localparam logic [2:0] CAP_WAIT_LOW = 3'd1;
    localparam logic [2:0] CAP_WAIT_HIGH = 3'd2;
    localparam logic [2:0] CAP_HEADER = 3'd3;
    localparam logic [2:0] CAP_PIXELS = 3'd4;

    // Command sequencer
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_CAPTURE,
        CTRL_READOUT
    } ctrl_state_t;

    // Stored word, seen raw or as a zero-padded pixel
    typedef union packed {
        logic [WORD_WIDTH-1:0] raw;
        struct packed {
            logic [WORD_WIDTH-PIXEL_WIDTH-1:0] pad;
            logic [PIXEL_WIDTH-1:0] pixel;
        } pix;
    } img_word_t;

endpackage
